/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = alarm_clock_tb
FILELIST  = alarm_clock.f
OBJ_DIR   = obj_dir
PASS_TEXT = NO ERRORS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* alarm_clock.f */
hw/clock_pkg.sv
hw/wrap_counter.sv
hw/timekeeper.sv
hw/alarm_tone.sv
hw/seg_scan.sv
hw/alarm_clock.sv
testbench/alarm_clock_tb.sv

/* hw/alarm_clock.sv */
`timescale 1ns/10ps

module alarm_clock #(
   parameter int TICK_DIV = 50000000,
   parameter int SCAN_DIV = 2000,
   parameter int TONE_DIV = 28409
) (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              set_mode,
   input  logic                              cmd_req,
   input  clock_pkg::op_e                    cmd_op,
   output logic                              cmd_ack,
   output clock_pkg::seg_t                   seg,
   output logic [clock_pkg::NUM_DIGITS-1:0] an,
   output logic                              dp,
   output logic                              alarm_led,
   output logic                              sd,
   output logic                              pwm
);

   import clock_pkg::*;

   min_t tm_min;
   hr_t tm_hr;
   min_t alm_min;
   hr_t alm_hr;
   logic sec_even;
   field_e field;

   ////////////////////////////////////////
   // time base and settings
   ////////////////////////////////////////

   timekeeper #(.TICK_DIV(TICK_DIV)) timekeeper_inst (
      .clk(clk),
      .rst(rst),
      .set_mode(set_mode),
      .cmd_req(cmd_req),
      .cmd_op(cmd_op),
      .cmd_ack(cmd_ack),
      .tm_min(tm_min),
      .tm_hr(tm_hr),
      .alm_min(alm_min),
      .alm_hr(alm_hr),
      .sec_even(sec_even),
      .field(field)
   );

   // buzzer side
   alarm_tone #(.TONE_DIV(TONE_DIV)) alarm_tone_inst (
      .clk(clk),
      .rst(rst),
      .set_mode(set_mode),
      .tm_min(tm_min),
      .tm_hr(tm_hr),
      .alm_min(alm_min),
      .alm_hr(alm_hr),
      .alarm_led(alarm_led),
      .sd(sd),
      .pwm(pwm)
   );

   // display side
   seg_scan #(.SCAN_DIV(SCAN_DIV)) seg_scan_inst (
      .clk(clk),
      .rst(rst),
      .set_mode(set_mode),
      .tm_min(tm_min),
      .tm_hr(tm_hr),
      .alm_min(alm_min),
      .alm_hr(alm_hr),
      .sec_even(sec_even),
      .field(field),
      .seg(seg),
      .an(an),
      .dp(dp)
   );

endmodule

/* hw/alarm_tone.sv */
`timescale 1ns/10ps

module alarm_tone #(
   parameter int TONE_DIV = 28409
) (
   input  logic            clk,
   input  logic            rst,
   input  logic            set_mode,
   input  clock_pkg::min_t tm_min,
   input  clock_pkg::hr_t  tm_hr,
   input  clock_pkg::min_t alm_min,
   input  clock_pkg::hr_t  alm_hr,
   output logic            alarm_led,
   output logic            sd,
   output logic            pwm
);

   localparam int TONE_W = (TONE_DIV > 1) ? $clog2(TONE_DIV) : 1;

   logic match;
   logic [TONE_W-1:0] tone_cnt;

   // no alarm while the user is setting things
   assign match = !set_mode && (tm_hr == alm_hr) && (tm_min == alm_min);

   always_ff @(posedge clk) begin
      if (rst) begin
         alarm_led <= 1'b0;
         sd <= 1'b0;
      end else begin
         alarm_led <= match;
         sd <= match;
      end
   end

   ////////////////////////////////////////
   // tone divider
   ////////////////////////////////////////

   // square wave, half period of TONE_DIV cycles
   always_ff @(posedge clk) begin
      if (rst || !sd) begin
         tone_cnt <= '0;
         pwm <= 1'b0;
      end else if (tone_cnt == TONE_W'(TONE_DIV - 1)) begin
         tone_cnt <= '0;
         pwm <= ~pwm;
      end else begin
         tone_cnt <= tone_cnt + 1'b1;
      end
   end

   // speaker stays quiet once the amplifier is off
   a_quiet_when_off: assert property (
      @(posedge clk) disable iff (rst) !sd |=> !pwm
   ) else $error("pwm active while amplifier disabled");

endmodule

/* hw/clock_pkg.sv */
package clock_pkg;

   ////////////////////////////////////////
   // value types
   ////////////////////////////////////////

   // seconds and minutes 0..59
   typedef logic [5:0] min_t;
   // hours 0..23
   typedef logic [4:0] hr_t;
   // segments a..g, a in the msb, active low
   typedef logic [6:0] seg_t;

   // set-mode field, listed in rotation order
   typedef enum logic [1:0] {FIELD_MIN, FIELD_HR, FIELD_ALM_MIN, FIELD_ALM_HR} field_e;

   // button command carried by the handshake
   typedef enum logic [1:0] {OP_INC, OP_DEC, OP_NEXT} op_e;

   localparam min_t MIN_LAST = 6'd59;
   localparam hr_t HR_LAST = 5'd23;
   // alarm comes up at 06:00
   localparam hr_t ALM_RESET_HR = 5'd6;
   localparam int NUM_DIGITS = 8;

   ////////////////////////////////////////
   // segment decoding
   ////////////////////////////////////////

   function automatic seg_t seg_of_digit(input logic [3:0] digit);
      seg_t pattern;
      case (digit)
         4'd0: pattern = 7'b0000001;
         4'd1: pattern = 7'b1001111;
         4'd2: pattern = 7'b0010010;
         4'd3: pattern = 7'b0000110;
         4'd4: pattern = 7'b1001100;
         4'd5: pattern = 7'b0100100;
         4'd6: pattern = 7'b0100000;
         4'd7: pattern = 7'b0001111;
         4'd8: pattern = 7'b0000000;
         4'd9: pattern = 7'b0000100;
         // blank for anything out of range
         default: pattern = 7'b1111111;
      endcase
      return pattern;
   endfunction

endpackage

/* hw/seg_scan.sv */
`timescale 1ns/10ps

module seg_scan #(
   parameter int SCAN_DIV = 2000
) (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              set_mode,
   input  clock_pkg::min_t                   tm_min,
   input  clock_pkg::hr_t                    tm_hr,
   input  clock_pkg::min_t                   alm_min,
   input  clock_pkg::hr_t                    alm_hr,
   input  logic                              sec_even,
   input  clock_pkg::field_e                 field,
   output clock_pkg::seg_t                   seg,
   output logic [clock_pkg::NUM_DIGITS-1:0] an,
   output logic                              dp
);

   import clock_pkg::*;

   localparam int SCAN_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
   localparam int IDX_W = $clog2(NUM_DIGITS);

   logic [SCAN_W-1:0] scan_cnt;
   logic [IDX_W-1:0] idx;
   logic [1:0] pair;
   logic [5:0] val;
   logic [3:0] tens;
   logic [3:0] ones;
   seg_t seg_next;
   logic dp_next;

   ////////////////////////////////////////
   // digit scan
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         scan_cnt <= '0;
         idx <= '0;
      end else if (scan_cnt == SCAN_W'(SCAN_DIV - 1)) begin
         scan_cnt <= '0;
         if (idx == IDX_W'(NUM_DIGITS - 1)) begin
            idx <= '0;
         end else begin
            idx <= idx + 1'b1;
         end
      end else begin
         scan_cnt <= scan_cnt + 1'b1;
      end
   end

   ////////////////////////////////////////
   // digit contents
   ////////////////////////////////////////

   // two digits per value, pairs follow the field order
   assign pair = idx[IDX_W-1:1];

   always_comb begin
      case (pair)
         2'd0: val = tm_min;
         2'd1: val = 6'(tm_hr);
         2'd2: val = alm_min;
         default: val = 6'(alm_hr);
      endcase
   end

   assign tens = 4'(val / 6'd10);
   assign ones = 4'(val % 6'd10);
   // odd digits carry the tens
   assign seg_next = seg_of_digit(idx[0] ? tens : ones);

   always_comb begin
      if (set_mode) begin
         // mark both digits of the field being set
         dp_next = !(pair == field);
      end else begin
         // seconds blink after the hour ones digit
         dp_next = !((idx == IDX_W'(2)) && sec_even);
      end
   end

   // anode, segments and point change on the same edge
   always_ff @(posedge clk) begin
      if (rst) begin
         an <= ~NUM_DIGITS'(1);
         seg <= '1;
         dp <= 1'b1;
      end else begin
         an <= ~(NUM_DIGITS'(1) << idx);
         seg <= seg_next;
         dp <= dp_next;
      end
   end

endmodule

/* hw/timekeeper.sv */
`timescale 1ns/10ps

module timekeeper #(
   parameter int TICK_DIV = 50000000
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              set_mode,
   input  logic              cmd_req,
   input  clock_pkg::op_e    cmd_op,
   output logic              cmd_ack,
   output clock_pkg::min_t   tm_min,
   output clock_pkg::hr_t    tm_hr,
   output clock_pkg::min_t   alm_min,
   output clock_pkg::hr_t    alm_hr,
   output logic              sec_even,
   output clock_pkg::field_e field
);

   import clock_pkg::*;

   localparam int TICK_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

   logic [TICK_W-1:0] tick_cnt;
   logic tick;
   min_t sec;
   logic sec_carry;
   logic min_carry;
   logic min_up;
   logic hr_up;
   logic cmd_take;
   logic step;
   logic step_up;
   logic step_dn;

   ////////////////////////////////////////
   // second tick
   ////////////////////////////////////////

   // divider freezes in set mode
   assign tick = !set_mode && (tick_cnt == TICK_W'(TICK_DIV - 1));

   always_ff @(posedge clk) begin
      if (rst) begin
         tick_cnt <= '0;
      end else if (tick) begin
         tick_cnt <= '0;
      end else if (!set_mode) begin
         tick_cnt <= tick_cnt + 1'b1;
      end
   end

   ////////////////////////////////////////
   // command handshake
   ////////////////////////////////////////

   assign cmd_take = cmd_req && !cmd_ack;

   always_ff @(posedge clk) begin
      if (rst) begin
         cmd_ack <= 1'b0;
      end else if (cmd_take) begin
         cmd_ack <= 1'b1;
      end else if (!cmd_req) begin
         cmd_ack <= 1'b0;
      end
   end

   // outside set mode a command is only acknowledged
   assign step = cmd_take && set_mode;
   assign step_up = step && (cmd_op == OP_INC);
   assign step_dn = step && (cmd_op == OP_DEC);

   always_ff @(posedge clk) begin
      if (rst) begin
         field <= FIELD_MIN;
      end else if (step && (cmd_op == OP_NEXT)) begin
         field <= field_e'(field + 2'd1);
      end
   end

   ////////////////////////////////////////
   // time and alarm fields
   ////////////////////////////////////////

   // set-mode steps wrap in place, only the tick chain carries
   assign min_up = sec_carry || (step_up && (field == FIELD_MIN));
   assign hr_up = (min_carry && tick) || (step_up && (field == FIELD_HR));

   wrap_counter #(.count_t(min_t), .LAST(MIN_LAST)) sec_cnt (
      .clk(clk), .rst(rst), .up(tick), .down(1'b0), .value(sec), .wrap(sec_carry)
   );

   wrap_counter #(.count_t(min_t), .LAST(MIN_LAST)) min_cnt (
      .clk(clk), .rst(rst), .up(min_up), .down(step_dn && (field == FIELD_MIN)),
      .value(tm_min), .wrap(min_carry)
   );

   wrap_counter #(.count_t(hr_t), .LAST(HR_LAST)) hr_cnt (
      .clk(clk), .rst(rst), .up(hr_up), .down(step_dn && (field == FIELD_HR)),
      .value(tm_hr), .wrap()
   );

   wrap_counter #(.count_t(min_t), .LAST(MIN_LAST)) alm_min_cnt (
      .clk(clk), .rst(rst), .up(step_up && (field == FIELD_ALM_MIN)),
      .down(step_dn && (field == FIELD_ALM_MIN)), .value(alm_min), .wrap()
   );

   wrap_counter #(.count_t(hr_t), .LAST(HR_LAST), .RESET_VAL(ALM_RESET_HR)) alm_hr_cnt (
      .clk(clk), .rst(rst), .up(step_up && (field == FIELD_ALM_HR)),
      .down(step_dn && (field == FIELD_ALM_HR)), .value(alm_hr), .wrap()
   );

   assign sec_even = ~sec[0];

   // ack may only rise in answer to a request seen on the edge before
   a_ack_needs_req: assert property (
      @(posedge clk) disable iff (rst) $rose(cmd_ack) |-> $past(cmd_req)
   ) else $error("cmd_ack rose without cmd_req");

endmodule

/* hw/wrap_counter.sv */
`timescale 1ns/10ps

module wrap_counter #(
   parameter type count_t = logic [5:0],
   parameter count_t LAST = '1,
   parameter count_t RESET_VAL = '0
) (
   input  logic   clk,
   input  logic   rst,
   input  logic   up,
   input  logic   down,
   output count_t value,
   output logic   wrap
);

   // up has priority if both arrive together
   always_ff @(posedge clk) begin
      if (rst) begin
         value <= RESET_VAL;
      end else if (up) begin
         if (value == LAST) begin
            value <= '0;
         end else begin
            value <= count_t'(value + 1'b1);
         end
      end else if (down) begin
         if (value == '0) begin
            value <= LAST;
         end else begin
            value <= count_t'(value - 1'b1);
         end
      end
   end

   // carry into the next field
   assign wrap = up && (value == LAST);

   ////////////////////////////////////////
   // checks
   ////////////////////////////////////////

   a_in_range: assert property (@(posedge clk) disable iff (rst) value <= LAST)
      else $error("wrap_counter value %0d beyond last %0d", value, LAST);

endmodule

/* testbench/alarm_clock_tb.sv */
`timescale 1ns/10ps

module alarm_clock_tb;

   import clock_pkg::*;

   localparam int TICK_DIV = 40;
   localparam int SCAN_DIV = 2;
   localparam int TONE_DIV = 3;
   localparam int DRIVE_DELAY = 2;
   localparam int HANDSHAKE_LIMIT = 10;
   // second ticks that all directed tests need together
   localparam int TEST_SECONDS = 200;

   logic clk;
   logic rst;
   logic set_mode;
   logic cmd_req;
   op_e cmd_op;
   logic cmd_ack;
   seg_t seg;
   logic [NUM_DIGITS-1:0] an;
   logic dp;
   logic alarm_led;
   logic sd;
   logic pwm;

   int errors;
   // reference time following the tick rules
   int m_phase;
   int m_sec;
   int m_min;
   int m_hr;
   // expected alarm and selected field
   int e_alm_min;
   int e_alm_hr;
   int e_field;
   // last display read
   int rd_tm_min;
   int rd_tm_hr;
   int rd_alm_min;
   int rd_alm_hr;
   int rd_dp [NUM_DIGITS];
   int rd_sec;

   alarm_clock #(
      .TICK_DIV(TICK_DIV),
      .SCAN_DIV(SCAN_DIV),
      .TONE_DIV(TONE_DIV)
   ) alarm_clock_inst (
      .clk(clk), .rst(rst), .set_mode(set_mode), .cmd_req(cmd_req), .cmd_op(cmd_op),
      .cmd_ack(cmd_ack), .seg(seg), .an(an), .dp(dp),
      .alarm_led(alarm_led), .sd(sd), .pwm(pwm)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // time chain reference that holds in set mode
   always @(posedge clk) begin
      if (rst) begin
         m_phase = 0;
         m_sec = 0;
         m_min = 0;
         m_hr = 0;
      end else if (!set_mode) begin
         if (m_phase == TICK_DIV - 1) begin
            m_phase = 0;
            m_sec = (m_sec + 1) % 60;
            if (m_sec == 0) begin
               m_min = (m_min + 1) % 60;
               if (m_min == 0) begin
                  m_hr = (m_hr + 1) % 24;
               end
            end
         end else begin
            m_phase++;
         end
      end
   end

   initial begin
      repeat ((TEST_SECONDS + 20) * TICK_DIV) @(posedge clk);
      $display("watchdog expired before the tests finished");
      $display("errors: %0d", errors);
      $display("ERRORS FOUND");
      $finish;
   end

   ////////////////////////////////////////
   // helpers
   ////////////////////////////////////////

   task automatic check_value(input string name, input int expected, input int actual);
      if (expected != actual) begin
         $display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
         errors++;
      end
   endtask

   task automatic report_failure(input string what);
      $display("%s", what);
      errors++;
   endtask

   task automatic next_drive_slot;
      @(posedge clk);
      #DRIVE_DELAY;
   endtask

   // lit segments a..g with a in the msb
   function automatic int digit_of_seg(input seg_t pattern);
      case (~pattern)
         7'b1111110: return 0;
         7'b0110000: return 1;
         7'b1101101: return 2;
         7'b1111001: return 3;
         7'b0110011: return 4;
         7'b1011011: return 5;
         7'b1011111: return 6;
         7'b1110000: return 7;
         7'b1111111: return 8;
         7'b1111011: return 9;
         default: return -100;
      endcase
   endfunction

   // index of the single low anode line or a negative code
   function automatic int active_digit(input logic [NUM_DIGITS-1:0] lines);
      int found;
      found = -1;
      for (int i = 0; i < NUM_DIGITS; i++) begin
         if (!lines[i]) begin
            found = (found == -1) ? i : -2;
         end
      end
      return found;
   endfunction

   function automatic int step_value(input int value, input int last, input op_e op);
      if (op == OP_INC) begin
         return (value == last) ? 0 : value + 1;
      end
      if (op == OP_DEC) begin
         return (value == 0) ? last : value - 1;
      end
      return value;
   endfunction

   function automatic int expected_dp(input int digit, input logic in_set, input int sec);
      if (in_set) begin
         return (digit / 2 == e_field) ? 0 : 1;
      end
      return (digit == 2 && sec % 2 == 0) ? 0 : 1;
   endfunction

   task automatic apply_reset;
      next_drive_slot();
      rst = 1'b1;
      set_mode = 1'b0;
      cmd_req = 1'b0;
      repeat (3) @(posedge clk);
      #DRIVE_DELAY;
      check_value("reset an", 8'hfe, an);
      rst = 1'b0;
      e_alm_min = 0;
      e_alm_hr = 6;
      e_field = 0;
   endtask

   // one full pass over the scan decoded into four values
   task automatic read_digits;
      int seen;
      int cycles;
      int idx;
      int value [NUM_DIGITS];
      seen = 0;
      cycles = 0;
      // start right after a tick so the time holds during the pass
      while (!set_mode && m_phase != 1) @(negedge clk);
      // registered outputs need one edge to follow a change of inputs
      @(negedge clk);
      while (seen != 'hff && cycles < 4 * NUM_DIGITS * SCAN_DIV) begin
         @(negedge clk);
         cycles++;
         idx = active_digit(an);
         if (idx < 0) begin
            report_failure("anode lines do not select exactly one digit");
         end else begin
            value[idx] = digit_of_seg(seg);
            rd_dp[idx] = dp;
            if (idx == 2) begin
               rd_sec = m_sec;
            end
            seen |= 1 << idx;
         end
      end
      if (seen != 'hff) begin
         report_failure("display scan did not reach all eight digits");
      end
      rd_tm_min = value[1] * 10 + value[0];
      rd_tm_hr = value[3] * 10 + value[2];
      rd_alm_min = value[5] * 10 + value[4];
      rd_alm_hr = value[7] * 10 + value[6];
   endtask

   task automatic check_display(input string name);
      read_digits();
      check_value({name, " time minute"}, m_min, rd_tm_min);
      check_value({name, " time hour"}, m_hr, rd_tm_hr);
      check_value({name, " alarm minute"}, e_alm_min, rd_alm_min);
      check_value({name, " alarm hour"}, e_alm_hr, rd_alm_hr);
      for (int i = 0; i < NUM_DIGITS; i++) begin
         check_value($sformatf("%s dp%0d", name, i), expected_dp(i, set_mode, rd_sec), rd_dp[i]);
      end
   endtask

   task automatic send_cmd(input op_e op);
      int waited;
      next_drive_slot();
      cmd_op = op;
      cmd_req = 1'b1;
      waited = 0;
      while (!cmd_ack && waited < HANDSHAKE_LIMIT) begin
         next_drive_slot();
         waited++;
      end
      if (!cmd_ack) begin
         report_failure("cmd_ack did not rise within 10 cycles of cmd_req");
      end
      cmd_req = 1'b0;
      waited = 0;
      while (cmd_ack && waited < HANDSHAKE_LIMIT) begin
         next_drive_slot();
         waited++;
      end
      if (cmd_ack) begin
         report_failure("cmd_ack did not fall within 10 cycles after cmd_req dropped");
      end
   endtask

   // command plus its expected effect
   task automatic apply_cmd(input op_e op);
      send_cmd(op);
      if (set_mode) begin
         case (e_field)
            0: m_min = step_value(m_min, 59, op);
            1: m_hr = step_value(m_hr, 23, op);
            2: e_alm_min = step_value(e_alm_min, 59, op);
            default: e_alm_hr = step_value(e_alm_hr, 23, op);
         endcase
         if (op == OP_NEXT) begin
            e_field = (e_field + 1) % 4;
         end
      end
   endtask

   ////////////////////////////////////////
   // directed tests
   ////////////////////////////////////////

   task automatic reset_values;
      apply_reset();
      check_display("reset");
      check_value("reset alarm_led", 0, alarm_led);
      check_value("reset sd", 0, sd);
      check_value("reset pwm", 0, pwm);
      check_value("reset cmd_ack", 0, cmd_ack);
   endtask

   task automatic time_runs;
      apply_reset();
      repeat (61 * TICK_DIV) @(posedge clk);
      check_display("time runs");
      check_value("time runs minute", 1, rd_tm_min);
      check_value("time runs hour", 0, rd_tm_hr);
      // consecutive passes land on consecutive seconds
      repeat (4) check_display("seconds point");
   endtask

   task automatic set_stepping;
      apply_reset();
      next_drive_slot();
      set_mode = 1'b1;
      apply_cmd(OP_DEC);
      check_display("minute down");
      check_value("minute wraps down", 59, rd_tm_min);
      apply_cmd(OP_INC);
      check_display("minute up");
      apply_cmd(OP_NEXT);
      apply_cmd(OP_DEC);
      check_display("hour down");
      check_value("hour wraps down", 23, rd_tm_hr);
      apply_cmd(OP_NEXT);
      apply_cmd(OP_DEC);
      check_display("alarm minute down");
      apply_cmd(OP_INC);
      check_display("alarm minute up");
      apply_cmd(OP_NEXT);
      apply_cmd(OP_DEC);
      check_display("alarm hour down");
      apply_cmd(OP_INC);
      apply_cmd(OP_NEXT);
      check_display("field rotation");
   endtask

   task automatic freeze_in_set;
      int held_min;
      int held_hr;
      check_display("freeze start");
      held_min = rd_tm_min;
      held_hr = rd_tm_hr;
      repeat (3 * TICK_DIV) @(posedge clk);
      check_display("freeze end");
      check_value("frozen minute", held_min, rd_tm_min);
      check_value("frozen hour", held_hr, rd_tm_hr);
   endtask

   task automatic alarm_fires;
      int waited;
      int toggles;
      logic last_pwm;
      while (e_field != 2) apply_cmd(OP_NEXT);
      while (e_alm_min != m_min) apply_cmd(OP_INC);
      apply_cmd(OP_NEXT);
      while (e_alm_hr != m_hr) apply_cmd(OP_INC);
      next_drive_slot();
      set_mode = 1'b0;
      waited = 0;
      while (!alarm_led && waited < 4) begin
         @(negedge clk);
         waited++;
      end
      check_value("alarm lamp on", 1, alarm_led);
      check_value("amplifier on", 1, sd);
      // square tone with one toggle per TONE_DIV cycles
      toggles = 0;
      last_pwm = pwm;
      repeat (10 * TONE_DIV) begin
         @(negedge clk);
         if (pwm != last_pwm) begin
            toggles++;
         end
         last_pwm = pwm;
      end
      check_value("tone toggles", 10, toggles);
      check_display("alarm match");
      next_drive_slot();
      set_mode = 1'b1;
      apply_cmd(OP_INC);
      repeat (2 * TONE_DIV) @(negedge clk);
      check_value("changed alarm lamp", 0, alarm_led);
      check_value("changed amplifier", 0, sd);
      check_value("changed tone", 0, pwm);
      next_drive_slot();
      set_mode = 1'b0;
      check_display("alarm moved");
      check_value("moved alarm lamp", 0, alarm_led);
      check_value("moved amplifier", 0, sd);
      check_value("moved tone", 0, pwm);
   endtask

   task automatic idle_commands;
      check_display("idle before");
      apply_cmd(OP_INC);
      check_display("idle inc");
      apply_cmd(OP_DEC);
      check_display("idle dec");
      apply_cmd(OP_NEXT);
      check_display("idle next");
      // field must still be where set mode left it
      next_drive_slot();
      set_mode = 1'b1;
      check_display("idle field");
   endtask

   initial begin
      errors = 0;
      rst = 1'b1;
      set_mode = 1'b0;
      cmd_req = 1'b0;
      cmd_op = OP_INC;
      reset_values();
      time_runs();
      set_stepping();
      freeze_in_set();
      alarm_fires();
      idle_commands();
      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule
